/* compile.f */
fetch_pkg.sv
l15_pkg.sv
fetch_cfg_regs.sv
pc_gen.sv
l15_fetch_port.sv
frontend_top.sv
tb_l15_model.sv
tb_frontend_top.sv

/* fetch_cfg_regs.sv */
module fetch_cfg_regs #(
	parameter logic [31:0] BOOT_VECTOR = 32'h4000_0000
) (
	input  logic        clk,
	input  logic        nrst,
	input  logic        cfg_we,
	input  logic [31:0] cfg_wdata,
	output logic [31:0] boot_vec
);

	logic [31:0] boot_vec_q;

	// software may move the boot vector at any time
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			boot_vec_q <= BOOT_VECTOR;
		end
		else if (cfg_we)
		begin
			boot_vec_q <= cfg_wdata;
		end
	end

	assign boot_vec = boot_vec_q;

	// a misaligned boot vector would break every later fetch
	boot_vec_aligned: assert property (@(posedge clk) disable iff (!nrst)
		cfg_we |=> boot_vec[1:0] == 2'b00)
		else $error("boot vector written unaligned: %h", boot_vec);

endmodule

/* fetch_patterns.txt */
# sel target st kd mem bsy we wdata fen ftype lat exp_addr exp_pc2 (target, wdata, ftype, addresses in hex)
# sel 0 seq 1 boot 2 target 3 hold, kd 0 rewind 1 advance 2 or 3 hold, lat -1 is random 0 to 3
0 00000000 0 0 0 0 0 00000000 0 0 0 40000000 40000000
0 00000000 0 0 0 0 0 00000000 0 0 1 40000004 40000004
0 00000000 0 0 0 0 0 00000000 0 0 -1 40000008 40000008
0 00000000 0 0 0 0 0 00000000 0 0 2 4000000c 4000000c
2 00001000 0 0 0 0 0 00000000 0 0 0 40000010 40000010
0 00000000 0 0 0 0 0 00000000 0 0 0 00001000 00001000
0 00000000 1 2 0 0 0 00000000 0 0 1 00001004 00001000
0 00000000 0 0 1 0 0 00000000 0 0 0 00001004 00001000
0 00000000 0 0 0 1 0 00000000 0 0 2 00001004 00001000
0 00000000 0 0 0 0 0 00000000 0 0 0 00001004 00001004
0 00000000 1 0 0 0 0 00000000 0 0 0 00001008 00001000
0 00000000 0 0 0 0 0 00000000 0 0 1 00001004 00001004
0 00000000 1 1 0 0 0 00000000 0 0 0 00001008 00001008
1 00000000 0 0 0 0 0 00000000 0 0 0 0000100c 0000100c
0 00000000 0 0 0 0 1 20000000 0 0 -1 40000000 40000000
1 00000000 0 0 0 0 0 00000000 1 4 0 40000004 40000004
0 00000000 0 0 0 0 0 00000000 1 c 1 20000000 20000000
3 00000000 0 0 0 0 0 00000000 0 0 0 20000004 20000004
0 00000000 0 0 0 0 0 00000000 0 0 -1 20000004 20000004
2 00002008 0 0 0 0 0 00000000 0 0 0 20000008 20000008
0 00000000 0 0 0 0 0 00000000 0 0 2 00002008 00002008

/* fetch_pkg.sv */
package fetch_pkg;

	// cache port sequencing
	typedef enum logic {
		FS_ISSUE = 1'b0, // request may go out
		FS_WAIT  = 1'b1  // request taken and line still owed
	} fetch_state_e;

	// next pc choice applied when a fetch completes
	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0,
		PC_BOOT   = 2'd1,
		PC_TARGET = 2'd2,
		PC_HOLD   = 2'd3
	} pc_sel_e;

	// meaning of the decode stall kind while stall is high
	typedef enum logic [1:0] {
		STALL_REWIND  = 2'b00, // both pcs step back one word
		STALL_ADVANCE = 2'b01, // pipeline steps anyway
		STALL_HOLD_A  = 2'b10,
		STALL_HOLD_B  = 2'b11
	} stall_kind_e;

	// add x0, x0, x0
	localparam logic [31:0] NOP_INSTR = 32'h0000_0033;

endpackage

/* frontend_top.sv */
module frontend_top #(
	parameter logic [31:0] BOOT_VECTOR = 32'h4000_0000
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  logic                    stall,
	input  fetch_pkg::stall_kind_e  stall_kind,
	input  logic                    stall_mem,
	input  logic                    arb_mem_busy,
	input  fetch_pkg::pc_sel_e      pc_sel,
	input  logic [31:0]             target,
	input  logic                    cfg_we,
	input  logic [31:0]             cfg_wdata,
	output logic [31:0]             pc2,
	output logic [31:0]             instr2,
	output fetch_pkg::fetch_state_e fetch_state,
	output l15_pkg::l15_rqtype_e    rq_type,
	output logic [2:0]              rq_size,
	output logic [31:0]             rq_address,
	output logic                    rq_val,
	input  logic                    header_ack,
	input  logic                    resp_val,
	input  logic [63:0]             resp_data_0,
	input  logic [63:0]             resp_data_1,
	input  l15_pkg::l15_rettype_e   resp_rettype,
	output logic                    resp_ack
);

	logic [31:0] boot_vec;
	logic [31:0] fetch_pc;
	logic        awake;
	logic        fetch_done;

	fetch_cfg_regs #(
		.BOOT_VECTOR (BOOT_VECTOR)
	) fetch_cfg_regs_inst (
		.clk       (clk),
		.nrst      (nrst),
		.cfg_we    (cfg_we),
		.cfg_wdata (cfg_wdata),
		.boot_vec  (boot_vec)
	);

	pc_gen pc_gen_inst (
		.clk          (clk),
		.nrst         (nrst),
		.awake        (awake),
		.fetch_done   (fetch_done),
		.pc_sel       (pc_sel),
		.target       (target),
		.boot_vec     (boot_vec),
		.stall        (stall),
		.stall_kind   (stall_kind),
		.stall_mem    (stall_mem),
		.arb_mem_busy (arb_mem_busy),
		.fetch_pc     (fetch_pc),
		.pc2          (pc2)
	);

	l15_fetch_port l15_fetch_port_inst (
		.clk          (clk),
		.nrst         (nrst),
		.fetch_pc     (fetch_pc),
		.awake        (awake),
		.fetch_done   (fetch_done),
		.instr2       (instr2),
		.fetch_state  (fetch_state),
		.rq_type      (rq_type),
		.rq_size      (rq_size),
		.rq_address   (rq_address),
		.rq_val       (rq_val),
		.header_ack   (header_ack),
		.resp_val     (resp_val),
		.resp_data_0  (resp_data_0),
		.resp_data_1  (resp_data_1),
		.resp_rettype (resp_rettype),
		.resp_ack     (resp_ack)
	);

endmodule

/* l15_fetch_port.sv */
module l15_fetch_port (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic [31:0]            fetch_pc,
	output logic                   awake,
	output logic                   fetch_done,
	output logic [31:0]            instr2,
	output fetch_pkg::fetch_state_e fetch_state,
	output l15_pkg::l15_rqtype_e   rq_type,
	output logic [2:0]             rq_size,
	output logic [31:0]            rq_address,
	output logic                   rq_val,
	input  logic                   header_ack,
	input  logic                   resp_val,
	input  logic [63:0]            resp_data_0,
	input  logic [63:0]            resp_data_1,
	input  l15_pkg::l15_rettype_e  resp_rettype,
	output logic                   resp_ack
);
	import fetch_pkg::*;
	import l15_pkg::*;

	fetch_state_e state_q;
	logic         awake_q;
	logic         wake_evt;
	logic         req_fire;
	logic         fetch_resp; // load or ifill return
	logic [1:0]   word_sel_q; // addr[3:2] of the request in flight
	logic [31:0]  line_word;

	assign wake_evt   = !awake_q && resp_val && (resp_rettype == L15_INT_RET);
	assign fetch_resp = resp_val &&
		(resp_rettype == L15_LOAD_RET || resp_rettype == L15_IFILL_RET);
	assign req_fire   = rq_val && header_ack;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			awake_q <= 1'b0;
		else if (wake_evt)
			awake_q <= 1'b1; // sticky until the next reset
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state_q <= FS_ISSUE;
		end
		else
		begin
			case (state_q)
				FS_ISSUE:
				begin
					if (req_fire)
						state_q <= FS_WAIT;
				end
				default:
				begin
					if (fetch_resp)
						state_q <= FS_ISSUE; // store-ack or error keeps waiting
				end
			endcase
		end
	end

	// word offset held so a rewind during the wait cannot shift the select
	always_ff @(posedge clk)
	begin
		if (req_fire)
			word_sel_q <= fetch_pc[3:2];
	end

	always_comb
	begin
		case (word_sel_q)
			2'b00:   line_word = resp_data_0[63:32];
			2'b01:   line_word = resp_data_0[31:0];
			2'b10:   line_word = resp_data_1[63:32];
			default: line_word = resp_data_1[31:0];
		endcase
	end

	assign fetch_done = (state_q == FS_WAIT) && fetch_resp;

	// big-endian line word turned little-endian for the core
	assign instr2 = fetch_done ?
		{line_word[7:0], line_word[15:8], line_word[23:16], line_word[31:24]} : NOP_INSTR;

	assign rq_val     = awake_q && (state_q == FS_ISSUE);
	assign rq_address = fetch_pc;
	assign rq_type    = L15_LOAD_RQ;
	assign rq_size    = L15_SIZE_4B;
	assign resp_ack   = resp_val && (awake_q || wake_evt); // everything acked once awake

	assign awake       = awake_q;
	assign fetch_state = state_q;

	// the cache takes one header at a time
	one_outstanding: assert property (@(posedge clk) disable iff (!nrst)
		(state_q == FS_WAIT) |-> !header_ack)
		else $error("header acked while a fetch is still waiting");

	// a line only comes back for the request in flight
	line_requested: assert property (@(posedge clk) disable iff (!nrst)
		fetch_resp && awake_q |-> state_q == FS_WAIT)
		else $error("fetch line returned with no request waiting");

endmodule

/* l15_pkg.sv */
package l15_pkg;

	// return types on the response side of the l1.5 port
	typedef enum logic [3:0] {
		L15_LOAD_RET    = 4'b0000,
		L15_IFILL_RET   = 4'b0001,
		L15_STRLOAD_RET = 4'b0010,
		L15_INV_RET     = 4'b0011, // also atomic ack and evict
		L15_ST_ACK      = 4'b0100,
		L15_TEST_RET    = 4'b0101,
		L15_STRST_ACK   = 4'b0110,
		L15_INT_RET     = 4'b0111,
		L15_FP_RET      = 4'b1000,
		L15_FWD_RQ_RET  = 4'b1010,
		L15_FWD_RPY_RET = 4'b1011,
		L15_ERR_RET     = 4'b1100,
		L15_RSVD_RET    = 4'b1111
	} l15_rettype_e;

	// request types of which the fetch side only issues loads
	typedef enum logic [4:0] {
		L15_LOAD_RQ  = 5'b00000,
		L15_STORE_RQ = 5'b00001,
		L15_IMISS_RQ = 5'b10000
	} l15_rqtype_e;

	localparam logic [2:0] L15_SIZE_4B = 3'b010;

endpackage

/* pc_gen.sv */
module pc_gen (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   awake,
	input  logic                   fetch_done,
	input  fetch_pkg::pc_sel_e     pc_sel,
	input  logic [31:0]            target,
	input  logic [31:0]            boot_vec,
	input  logic                   stall,
	input  fetch_pkg::stall_kind_e stall_kind,
	input  logic                   stall_mem,
	input  logic                   arb_mem_busy,
	output logic [31:0]            fetch_pc,
	output logic [31:0]            pc2
);
	import fetch_pkg::*;

	logic [31:0] pc1_q; // pc being fetched
	logic [31:0] pc2_q; // pc of the last completed fetch
	logic [31:0] npc;
	logic        rewind;
	logic        step;

	assign rewind = stall && (stall_kind == STALL_REWIND);
	// memory side stalls win over an advance request
	assign step = (!stall || stall_kind == STALL_ADVANCE) && !stall_mem && !arb_mem_busy;

	always_comb
	begin
		npc = pc1_q; // same address until a fetch completes
		if (fetch_done)
		begin
			case (pc_sel)
				PC_SEQ:    npc = pc1_q + 32'd4;
				PC_BOOT:   npc = boot_vec;
				PC_TARGET: npc = target;
				default:   npc = pc1_q;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc1_q <= '0;
			pc2_q <= '0;
		end
		else if (!awake)
		begin
			// track the boot vector until the first wake-up
			pc1_q <= boot_vec;
			pc2_q <= boot_vec;
		end
		else if (rewind)
		begin
			pc1_q <= pc1_q - 32'd4;
			pc2_q <= pc2_q - 32'd4;
		end
		else if (step)
		begin
			pc1_q <= npc;
			if (fetch_done)
				pc2_q <= pc1_q; // fetched address moves to stage two
		end
	end

	// rewind shows up on the outputs in the same cycle
	always_comb
	begin
		if (!awake)
		begin
			fetch_pc = boot_vec;
			pc2      = boot_vec;
		end
		else if (rewind)
		begin
			fetch_pc = pc1_q - 32'd4;
			pc2      = pc2_q - 32'd4;
		end
		else
		begin
			fetch_pc = pc1_q;
			pc2      = pc2_q;
		end
	end

	pc_aligned: assert property (@(posedge clk) disable iff (!nrst)
		awake |=> pc1_q[1:0] == 2'b00)
		else $error("fetch pc lost word alignment: %h", pc1_q);

endmodule

/* tb_frontend_top.sv */
module tb_frontend_top;
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;
	import l15_pkg::*;

	localparam logic [31:0] BOOT_VECTOR = 32'h4000_0000;
	localparam int          TIMEOUT     = 200; // cycles per wait

	logic         clk;
	logic         nrst;
	logic         stall;
	stall_kind_e  stall_kind;
	logic         stall_mem;
	logic         arb_mem_busy;
	pc_sel_e      pc_sel;
	logic [31:0]  target;
	logic         cfg_we;
	logic [31:0]  cfg_wdata;
	logic [31:0]  pc2;
	logic [31:0]  instr2;
	fetch_state_e fetch_state;
	l15_rqtype_e  rq_type;
	logic [2:0]   rq_size;
	logic [31:0]  rq_address;
	logic         rq_val;
	logic         header_ack;
	logic         resp_val;
	logic [63:0]  resp_data_0;
	logic [63:0]  resp_data_1;
	l15_rettype_e resp_rettype;
	logic         resp_ack;

	logic         serve;
	int           latency;
	logic         foreign_en;
	l15_rettype_e foreign_type;
	logic         inject;
	l15_rettype_e inject_type;
	logic         line_due;

	int           errors;
	int           timeouts;
	int           steps;
	int           fd;
	int           n;
	int           cnt;
	logic [8*160-1:0] line_buf;
	logic         due_seen;
	// fields of one pattern line
	int           v_sel, v_stall, v_kind, v_mem, v_busy, v_we, v_fen, v_ftype, v_lat;
	logic [31:0]  v_target, v_wdata, v_addr, v_pc2;

	frontend_top #(
		.BOOT_VECTOR (BOOT_VECTOR)
	) frontend_top_inst (
		.clk (clk), .nrst (nrst), .stall (stall), .stall_kind (stall_kind),
		.stall_mem (stall_mem), .arb_mem_busy (arb_mem_busy), .pc_sel (pc_sel),
		.target (target), .cfg_we (cfg_we), .cfg_wdata (cfg_wdata), .pc2 (pc2),
		.instr2 (instr2), .fetch_state (fetch_state), .rq_type (rq_type),
		.rq_size (rq_size), .rq_address (rq_address), .rq_val (rq_val),
		.header_ack (header_ack), .resp_val (resp_val), .resp_data_0 (resp_data_0),
		.resp_data_1 (resp_data_1), .resp_rettype (resp_rettype), .resp_ack (resp_ack)
	);

	tb_l15_model l15_model_inst (
		.clk (clk), .serve (serve), .latency (latency), .foreign_en (foreign_en),
		.foreign_type (foreign_type), .inject (inject), .inject_type (inject_type),
		.rq_val (rq_val), .rq_address (rq_address), .header_ack (header_ack),
		.resp_val (resp_val), .resp_rettype (resp_rettype), .resp_data_0 (resp_data_0),
		.resp_data_1 (resp_data_1), .line_due (line_due)
	);

	always #10 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		errors = errors + 1;
	endtask

	task automatic report_failure(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		errors = errors + 1;
	endtask

	task automatic report_timeout(input string msg);
		$display("Timeout at %0t ns: %s", $time, msg);
		timeouts = timeouts + 1;
	endtask

	// lone response outside any fetch
	task automatic send_response(input l15_rettype_e kind);
		@(posedge clk);
		inject      <= 1'b1;
		inject_type <= kind;
		@(posedge clk);
		inject <= 1'b0;
		@(negedge clk);
		if (!resp_val)
			report_failure("cache model did not return the injected response");
	endtask

	task run_step;
		@(posedge clk);
		pc_sel       <= pc_sel_e'(v_sel[1:0]);
		target       <= v_target;
		cfg_we       <= v_we[0];
		cfg_wdata    <= v_wdata;
		latency      <= v_lat;
		foreign_en   <= v_fen[0];
		foreign_type <= l15_rettype_e'(v_ftype[3:0]);
		serve        <= 1'b1;
		@(posedge clk);
		cfg_we <= 1'b0;
		@(negedge clk);
		cnt = 0;
		while (!rq_val && cnt < TIMEOUT)
		begin
			@(negedge clk);
			cnt = cnt + 1;
		end
		if (!rq_val)
		begin
			report_timeout("no fetch request was issued");
			return;
		end
		if (rq_address !== v_addr)
			report_mismatch("rq_address", rq_address, v_addr);
		if (rq_type !== L15_LOAD_RQ)
			report_mismatch("rq_type", rq_type, L15_LOAD_RQ);
		if (rq_size !== L15_SIZE_4B)
			report_mismatch("rq_size", rq_size, L15_SIZE_4B);
		cnt      = 0;
		due_seen = 1'b0;
		while (!due_seen && cnt < TIMEOUT)
		begin
			if (resp_val)
			begin
				if (resp_ack !== 1'b1)
					report_mismatch("resp_ack", resp_ack, 1);
				if (instr2 !== NOP_INSTR)
					report_mismatch("instr2", instr2, NOP_INSTR);
				if (fetch_state !== FS_WAIT)
					report_mismatch("fetch_state", fetch_state, FS_WAIT);
			end
			if (line_due)
				due_seen = 1'b1;
			else
			begin
				@(negedge clk);
				cnt = cnt + 1;
			end
		end
		if (!due_seen)
		begin
			report_timeout("no fetch response arrived");
			return;
		end
		// stalls cover the completion cycle only
		@(posedge clk);
		stall        <= v_stall[0];
		stall_kind   <= stall_kind_e'(v_kind[1:0]);
		stall_mem    <= v_mem[0];
		arb_mem_busy <= v_busy[0];
		serve        <= 1'b0;
		@(negedge clk);
		if (!resp_val || resp_rettype !== L15_IFILL_RET)
			report_failure("fetch line was not returned");
		if (resp_ack !== 1'b1)
			report_mismatch("resp_ack", resp_ack, 1);
		if (fetch_state !== FS_WAIT)
			report_mismatch("fetch_state", fetch_state, FS_WAIT);
		if (instr2 !== v_addr) // line words hold their own addresses
			report_mismatch("instr2", instr2, v_addr);
		@(posedge clk);
		stall        <= 1'b0;
		stall_mem    <= 1'b0;
		arb_mem_busy <= 1'b0;
		@(negedge clk);
		if (pc2 !== v_pc2)
			report_mismatch("pc2", pc2, v_pc2);
	endtask

	initial
	begin
		clk          = 1'b0;
		nrst         = 1'b0;
		stall        = 1'b0;
		stall_kind   = STALL_REWIND;
		stall_mem    = 1'b0;
		arb_mem_busy = 1'b0;
		pc_sel       = PC_SEQ;
		target       = '0;
		cfg_we       = 1'b0;
		cfg_wdata    = '0;
		serve        = 1'b0;
		latency      = 0;
		foreign_en   = 1'b0;
		foreign_type = L15_ST_ACK;
		inject       = 1'b0;
		inject_type  = L15_INT_RET;
		errors       = 0;
		timeouts     = 0;
		steps        = 0;
		repeat (4) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		// asleep until an interrupt return
		if (rq_val !== 1'b0)
			report_mismatch("rq_val", rq_val, 0);
		if (resp_ack !== 1'b0)
			report_mismatch("resp_ack", resp_ack, 0);
		if (instr2 !== NOP_INSTR)
			report_mismatch("instr2", instr2, NOP_INSTR);
		if (pc2 !== BOOT_VECTOR)
			report_mismatch("pc2", pc2, BOOT_VECTOR);
		send_response(L15_ST_ACK);
		if (resp_ack !== 1'b0)
			report_mismatch("resp_ack", resp_ack, 0);
		@(negedge clk);
		@(negedge clk);
		if (rq_val !== 1'b0)
			report_failure("front end woke up on a store ack");
		send_response(L15_INT_RET);
		if (resp_ack !== 1'b1)
			report_mismatch("resp_ack", resp_ack, 1);
		if (rq_val !== 1'b0)
			report_failure("fetch request issued in the wake-up cycle");
		@(negedge clk);
		if (rq_val !== 1'b1)
			report_failure("no fetch request after the interrupt return");
		fd = $fopen("fetch_patterns.txt", "r");
		if (fd == 0)
			report_failure("cannot open fetch_patterns.txt");
		else
		begin
			while (!$feof(fd) && timeouts == 0)
			begin
				if ($fgets(line_buf, fd) != 0)
				begin
					n = $sscanf(line_buf, "%d %h %d %d %d %d %d %h %d %h %d %h %h",
						v_sel, v_target, v_stall, v_kind, v_mem, v_busy, v_we, v_wdata,
						v_fen, v_ftype, v_lat, v_addr, v_pc2);
					if (n == 13) // comment lines do not parse
					begin
						run_step;
						steps = steps + 1;
					end
				end
			end
			$fclose(fd);
		end
		$display("%0d steps, %0d errors, %0d timeouts", steps, errors, timeouts);
		if (errors == 0 && timeouts == 0 && steps > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* tb_l15_model.sv */
module tb_l15_model (
	input  logic                  clk,
	input  logic                  serve,        // may take one fetch request
	input  int                    latency,      // cycles before ack and before line or -1 for random
	input  logic                  foreign_en,   // send foreign_type ahead of the line
	input  l15_pkg::l15_rettype_e foreign_type,
	input  logic                  inject,       // lone response outside any fetch
	input  l15_pkg::l15_rettype_e inject_type,
	input  logic                  rq_val,
	input  logic [31:0]           rq_address,
	output logic                  header_ack,
	output logic                  resp_val,
	output l15_pkg::l15_rettype_e resp_rettype,
	output logic [63:0]           resp_data_0,
	output logic [63:0]           resp_data_1,
	output logic                  line_due      // ifill goes out on the next edge
);
	timeunit 1ns;
	timeprecision 1ps;
	import l15_pkg::*;

	int          seed;
	int          cnt;
	logic        hdr_wait;     // counting down to the header ack
	logic        pending;      // header taken, line still owed
	logic        foreign_sent;
	logic [31:0] line_addr;

	// memory holds each word big-endian
	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic int pick_delay();
		if (latency < 0)
			return {$random(seed)} % 4;
		return latency;
	endfunction

	assign line_due = pending && (cnt == 0) && (!foreign_en || foreign_sent);

	initial
	begin
		seed         = 29;
		cnt          = 0;
		hdr_wait     = 1'b0;
		pending      = 1'b0;
		foreign_sent = 1'b0;
		line_addr    = '0;
		header_ack   = 1'b0;
		resp_val     = 1'b0;
		resp_rettype = L15_IFILL_RET;
		resp_data_0  = '0;
		resp_data_1  = '0;
		forever
		begin
			@(posedge clk);
			header_ack <= 1'b0;
			resp_val   <= 1'b0;
			if (inject)
			begin
				resp_val     <= 1'b1;
				resp_rettype <= inject_type;
				resp_data_0  <= '0;
				resp_data_1  <= '0;
			end
			else if (pending)
			begin
				if (cnt > 0)
					cnt = cnt - 1;
				else if (foreign_en && !foreign_sent)
				begin
					resp_val     <= 1'b1; // carries no data for the port to use
					resp_rettype <= foreign_type;
					resp_data_0  <= '0;
					resp_data_1  <= '0;
					foreign_sent = 1'b1;
				end
				else
				begin
					resp_val     <= 1'b1;
					resp_rettype <= L15_IFILL_RET;
					// every word holds its own address
					resp_data_0  <= {swap_bytes(line_addr), swap_bytes(line_addr + 32'd4)};
					resp_data_1  <= {swap_bytes(line_addr + 32'd8), swap_bytes(line_addr + 32'd12)};
					pending = 1'b0;
				end
			end
			else if (serve && rq_val)
			begin
				if (!hdr_wait)
				begin
					cnt      = pick_delay();
					hdr_wait = 1'b1;
				end
				if (cnt > 0)
					cnt = cnt - 1;
				else
				begin
					header_ack   <= 1'b1;
					line_addr    = {rq_address[31:4], 4'b0000};
					hdr_wait     = 1'b0;
					pending      = 1'b1;
					foreign_sent = 1'b0;
					cnt          = pick_delay(); // line latency
				end
			end
		end
	end

endmodule
